// File: run.sh
#!/usr/bin/env bash
# Build the scene loader testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module scene_loader_tb -f tb.f -o scene_loader_sim \
  && ./obj_dir/scene_loader_sim \
  || { echo "Simulation failed"; exit 1; }

// File: sim/scene_loader_checker.sv
`timescale 1ns/1ns

module scene_loader_checker
  import scene_pkg::*;
#(
  parameter int OBJ_BYTES = 6
) (
  input logic                            clk,
  input logic                            rst,
  input logic                            in_valid,
  input logic                            in_ready,
  input logic                            frame_done,
  input load_state_t                     state,
  input logic [max_len(OBJ_BYTES)*8-1:0] word
);

  // Back-pressure only in the cycle after the last payload byte.
  ready_low_only_in_commit: assert property (@(posedge clk) disable iff (rst)
    !in_ready |-> state == COMMIT && $past(state == PAYLOAD && in_valid && in_ready))
    else $error("in_ready low outside the commit cycle");

  frame_done_one_cycle: assert property (@(posedge clk) disable iff (rst)
    frame_done |=> !frame_done)
    else $error("frame_done held for more than one cycle");

  // Payload word held while the frame commits.
  no_accept_in_commit: assert property (@(posedge clk) disable iff (rst)
    state == COMMIT |=> $stable(word))
    else $error("payload word changed during COMMIT");

  // First cycle out of reset.
  reset_values: assert property (@(posedge clk)
    rst |=> (in_ready && !frame_done))
    else $error("in_ready or frame_done wrong after reset");

endmodule

// File: sim/scene_loader_tb.sv
`timescale 1ns/1ns

module scene_loader_tb;

  localparam int OBJ_BYTES = 6;
  localparam int MAX_OBJS = 16;
  localparam int CAM_LEN = 9;
  localparam int RUN_FRAMES = 20;
  localparam logic [31:0] SEED = 32'h5ec1;
  // Two passes over the frame list, 80 cycles per frame, plus two resets.
  localparam longint TIMEOUT_NS = (2 * 8 + 2 * RUN_FRAMES * 80) * 40;

  logic clk = 1'b0;
  logic rst;
  logic in_valid;
  logic [7:0] in_byte;
  logic in_ready;
  logic frame_done;
  logic [1:0] cam_sel;
  logic [71:0] cam_vec;
  logic [5:0] obj_raddr;
  logic [OBJ_BYTES*8-1:0] obj_rdata;
  logic [$clog2(MAX_OBJS + 1)-1:0] num_objs;

  logic [31:0] lfsr;
  logic use_gaps;
  logic reset_done;
  logic init_checked = 1'b0;
  int frames_sent;
  int frames_seen = 0;
  int done_pulses = 0;
  logic [7:0] sent_log [1024];
  int sent_count;

  // Reference copy of the scene.
  logic [71:0] ref_cam [4];
  logic [OBJ_BYTES*8-1:0] ref_obj [64];
  logic [7:0] ref_num;
  // DUT scene read back after the gapped pass.
  logic [71:0] snap_cam [4];
  logic [OBJ_BYTES*8-1:0] snap_obj [64];
  logic [7:0] snap_num;

  always #20 clk = ~clk;

  scene_loader #(.OBJ_BYTES(OBJ_BYTES), .MAX_OBJS(MAX_OBJS)) dut (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_byte    (in_byte),
    .in_ready   (in_ready),
    .frame_done (frame_done),
    .cam_sel    (cam_sel),
    .cam_vec    (cam_vec),
    .obj_raddr  (obj_raddr),
    .obj_rdata  (obj_rdata),
    .num_objs   (num_objs)
  );

  bind scene_loader scene_loader_checker #(.OBJ_BYTES(OBJ_BYTES)) u_checker (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .frame_done (frame_done),
    .state      (u_fsm.state),
    .word       (word)
  );

  // **************************************************
  // Random source and reference model
  // **************************************************

  function automatic bit next_bit();
    bit out;
    out = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(next_bit());
    end
    return v;
  endfunction

  function automatic int payload_len(input logic [7:0] cmd);
    if (cmd[7]) begin
      return CAM_LEN;
    end
    if (cmd[6]) begin
      return 1;
    end
    return OBJ_BYTES;
  endfunction

  // Empty scene, as after reset.
  function automatic void clear_ref();
    for (int i = 0; i < 4; i++) begin
      ref_cam[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      ref_obj[i] = '0;
    end
    ref_num = 8'd0;
  endfunction

  // Payload arrives first byte least significant.
  function automatic void frame_ref(input logic [7:0] cmd, input logic [71:0] pay);
    if (cmd[7]) begin
      ref_cam[cmd[1:0]] = pay;
    end else if (cmd[6]) begin
      if (int'(pay[7:0]) <= MAX_OBJS) begin
        ref_num = pay[7:0];
      end
    end else if (int'(cmd[5:0]) < MAX_OBJS) begin
      ref_obj[cmd[5:0]] = pay[OBJ_BYTES*8-1:0];
    end
  endfunction

  task automatic check_value(input logic [71:0] got, input logic [71:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  // **************************************************
  // Stimulus
  // **************************************************

  task automatic send_byte(input logic [7:0] b);
    logic taken;
    int gap;
    taken = 1'b0;
    in_valid = 1'b1;
    in_byte = b;
    while (!taken) begin
      taken = in_ready;
      @(posedge clk);
      #2;
    end
    in_valid = 1'b0;
    sent_log[sent_count] = b;
    sent_count++;
    // Gap bits are drawn in both passes so payloads repeat.
    gap = rand_bits(2);
    if (!use_gaps) begin
      gap = 0;
    end
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic send_frame(input logic [7:0] cmd, input int count);
    int len;
    len = payload_len(cmd);
    send_byte(cmd);
    for (int k = 0; k < len; k++) begin
      if (count >= 0) begin
        send_byte(8'(count));
      end else begin
        send_byte(8'(rand_bits(8)));
      end
    end
    frames_sent++;
  endtask

  task automatic run_frames();
    int idx;
    int cnt;
    for (int i = 0; i < 4; i++) begin
      send_frame(8'h80 | 8'(rand_bits(5) << 2) | 8'(i), -1);
    end
    for (int i = 0; i < 8; i++) begin
      idx = rand_bits(6) % MAX_OBJS;
      send_frame(8'(idx), -1);
    end
    // Out of range indices, payload must still be consumed.
    send_frame(8'(MAX_OBJS), -1);
    send_frame(8'd63, -1);
    idx = MAX_OBJS + rand_bits(6) % (64 - MAX_OBJS);
    send_frame(8'(idx), -1);
    idx = rand_bits(6);
    cnt = rand_bits(8) % (MAX_OBJS + 1);
    send_frame(8'h40 | 8'(idx), cnt);
    send_frame(8'h7f, MAX_OBJS + 1);
    send_frame(8'h40, 255);
    idx = rand_bits(6) % MAX_OBJS;
    send_frame(8'(idx), -1);
    send_frame(8'h40, MAX_OBJS);
  endtask

  // Scene as the DUT presents it on the read ports.
  task automatic snapshot_scene();
    for (int i = 0; i < 4; i++) begin
      cam_sel = 2'(i);
      #1;
      snap_cam[i] = cam_vec;
    end
    for (int i = 0; i < 64; i++) begin
      obj_raddr = 6'(i);
      #1;
      snap_obj[i] = obj_rdata;
    end
    snap_num = 8'(num_objs);
  endtask

  task automatic compare_with_snapshot();
    for (int i = 0; i < 4; i++) begin
      cam_sel = 2'(i);
      #1;
      check_value(cam_vec, snap_cam[i], "camera state, gapped vs gap-free run");
    end
    for (int i = 0; i < 64; i++) begin
      obj_raddr = 6'(i);
      #1;
      check_value(72'(obj_rdata), 72'(snap_obj[i]), "object state, gapped vs gap-free run");
    end
    check_value(72'(num_objs), 72'(snap_num), "count state, gapped vs gap-free run");
  endtask

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    in_byte = 8'h00;
    lfsr = SEED;
    use_gaps = 1'b1;
    reset_done = 1'b0;
    frames_sent = 0;
    sent_count = 0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_done = 1'b1;
    wait (init_checked);
    @(posedge clk);
    #2;
    run_frames();
    wait (frames_seen == frames_sent);
    snapshot_scene();
    // Empty scene again, then the same frames back to back.
    @(posedge clk);
    #2;
    rst = 1'b1;
    clear_ref();
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    lfsr = SEED;
    use_gaps = 1'b0;
    run_frames();
    wait (frames_seen == frames_sent);
    check_value(72'(done_pulses), 72'(frames_sent), "frame_done pulse count");
    compare_with_snapshot();
    $display("TEST RESULT: PASS");
    $finish;
  end

  // **************************************************
  // Compare and watchdog
  // **************************************************

  // Every cycle with frame_done high counts, so a stretched pulse shows up.
  always @(posedge clk) begin
    if (!rst && frame_done) begin
      done_pulses++;
    end
  end

  task automatic read_back_all();
    for (int i = 0; i < 4; i++) begin
      cam_sel = 2'(i);
      #1;
      check_value(cam_vec, ref_cam[i], $sformatf("camera vector %0d", i));
    end
    for (int i = 0; i < 64; i++) begin
      obj_raddr = 6'(i);
      #1;
      check_value(72'(obj_rdata), 72'(ref_obj[i]), $sformatf("object %0d", i));
    end
    check_value(72'(num_objs), 72'(ref_num), "num_objs");
  endtask

  initial begin : compare_proc
    logic [7:0] cmd;
    logic [71:0] pay;
    int len;
    int rd;
    cam_sel = 2'd0;
    obj_raddr = 6'd0;
    rd = 0;
    clear_ref();
    wait (reset_done);
    check_value(72'(in_ready), 72'd1, "in_ready after reset");
    check_value(72'(frame_done), 72'd0, "frame_done after reset");
    read_back_all();
    init_checked = 1'b1;
    forever begin
      wait (frame_done);
      @(posedge clk);
      #1;
      if (rd >= sent_count) begin
        $display("frame_done pulsed with no frame sent at %0t ns", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Unexpected frame_done");
      end
      cmd = sent_log[rd];
      rd++;
      len = payload_len(cmd);
      pay = '0;
      for (int k = 0; k < len; k++) begin
        pay[k*8 +: 8] = sent_log[rd];
        rd++;
      end
      frame_ref(cmd, pay);
      read_back_all();
      frames_seen++;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired, the frames did not all complete in time");
    $display("TEST RESULT: FAIL");
    $fatal(1, "Timeout");
  end

endmodule

// File: source/byte_counter.sv
`timescale 1ns/1ns
`default_nettype none

module byte_counter
  import scene_pkg::*;
#(
  parameter int OBJ_BYTES = 6
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic [LEN_W-1:0] len,
  input  logic             step,
  output logic             last
);

  localparam int MAX_LEN = max_len(OBJ_BYTES);
  localparam int LEN_W   = $clog2(MAX_LEN + 1);

  // Payload bytes still expected in this frame.
  logic [LEN_W-1:0] remaining;

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining <= '0;
    end else if (start) begin
      remaining <= len;
    end else if (step && remaining != '0) begin
      remaining <= remaining - 1'b1;
    end
  end

  assign last = (remaining == LEN_W'(1));

endmodule

`default_nettype wire

// File: source/camera_regs.sv
`timescale 1ns/1ns
`default_nettype none

module camera_regs
  import scene_pkg::*;
#(
  parameter int OBJ_BYTES = 6
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   commit,
  input  opcode_t                op,
  input  logic [5:0]             sel,
  input  logic [MAX_LEN*8-1:0]   word,
  input  logic [1:0]             cam_sel,
  output logic [CAM_WIDTH-1:0]   cam_vec
);

  localparam int MAX_LEN = max_len(OBJ_BYTES);

  // Origin, right, forward, up.
  logic [CAM_WIDTH-1:0] cam [4];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        cam[i] <= '0;
      end
    end else if (commit && op == OP_CAM) begin
      cam[sel[1:0]] <= word[CAM_WIDTH-1:0];
    end
  end

  assign cam_vec = cam[cam_sel];

endmodule

`default_nettype wire

// File: source/load_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module load_fsm
  import scene_pkg::*;
#(
  parameter int OBJ_BYTES = 6
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  logic [7:0]           in_byte,
  output logic                 in_ready,
  output logic                 cnt_start,
  output logic [LEN_W-1:0]     cnt_len,
  input  logic                 cnt_last,
  output logic                 shift_en,
  output logic                 commit,
  output opcode_t              op,
  output logic [5:0]           sel,
  output logic                 frame_done
);

  localparam int LEN_W = $clog2(max_len(OBJ_BYTES) + 1);

  load_state_t state;
  opcode_t     op_q;
  logic [5:0]  sel_q;
  opcode_t     dec_op;

  // Command decode, valid while a command byte sits on the input.
  always_comb begin
    if (in_byte[7]) begin
      dec_op  = OP_CAM;
      cnt_len = LEN_W'(CAM_BYTES);
    end else if (in_byte[6]) begin
      dec_op  = OP_NUM_OBJS;
      cnt_len = LEN_W'(1);
    end else begin
      dec_op  = OP_OBJ;
      cnt_len = LEN_W'(OBJ_BYTES);
    end
  end

  // Ready everywhere except the commit cycle.
  assign in_ready   = (state != COMMIT);
  assign cnt_start  = (state == IDLE) && in_valid;
  assign shift_en   = (state == PAYLOAD) && in_valid;
  assign commit     = (state == COMMIT);
  assign frame_done = (state == COMMIT);
  assign op         = op_q;
  assign sel        = sel_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      op_q  <= OP_CAM;
      sel_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (in_valid) begin
            op_q  <= dec_op;
            sel_q <= in_byte[5:0];
            state <= PAYLOAD;
          end
        end
        PAYLOAD: begin
          // Last payload byte taken, store it next cycle.
          if (in_valid && cnt_last) begin
            state <= COMMIT;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/object_store.sv
`timescale 1ns/1ns
`default_nettype none

module object_store
  import scene_pkg::*;
#(
  parameter int OBJ_BYTES = 6,
  parameter int MAX_OBJS  = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   commit,
  input  opcode_t                op,
  input  logic [5:0]             sel,
  input  logic [MAX_LEN*8-1:0]   word,
  input  logic [5:0]             obj_raddr,
  output logic [OBJ_WIDTH-1:0]   obj_rdata,
  output logic [CNT_W-1:0]       num_objs
);

  localparam int MAX_LEN   = max_len(OBJ_BYTES);
  localparam int OBJ_WIDTH = OBJ_BYTES * 8;
  localparam int IDX_W     = $clog2(MAX_OBJS);
  localparam int CNT_W     = $clog2(MAX_OBJS + 1);

  logic [OBJ_WIDTH-1:0] mem [MAX_OBJS];
  logic                 sel_ok;
  logic                 raddr_ok;
  logic                 count_ok;

  // **************************************************
  // Range checks
  // **************************************************

  assign sel_ok   = ({1'b0, sel} < 7'(MAX_OBJS));
  assign raddr_ok = ({1'b0, obj_raddr} < 7'(MAX_OBJS));
  assign count_ok = (word[7:0] <= 8'(MAX_OBJS));

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MAX_OBJS; i++) begin
        mem[i] <= '0;
      end
      num_objs <= '0;
    end else if (commit) begin
      // Bad index or count: payload already consumed, nothing stored.
      if (op == OP_OBJ && sel_ok) begin
        mem[sel[IDX_W-1:0]] <= word[OBJ_WIDTH-1:0];
      end
      if (op == OP_NUM_OBJS && count_ok) begin
        num_objs <= word[CNT_W-1:0];
      end
    end
  end

  assign obj_rdata = raddr_ok ? mem[obj_raddr[IDX_W-1:0]] : '0;

endmodule

`default_nettype wire

// File: source/payload_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module payload_shifter
  import scene_pkg::*;
#(
  parameter int OBJ_BYTES = 6
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clear,
  input  logic                   shift_en,
  input  logic [7:0]             in_byte,
  output logic [MAX_LEN*8-1:0]   word
);

  localparam int MAX_LEN = max_len(OBJ_BYTES);
  localparam int PTR_W   = $clog2(MAX_LEN);

  // Next byte lane to fill, so frames of any length end up right-aligned.
  logic [PTR_W-1:0] ptr;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      word <= '0;
      ptr  <= '0;
    end else if (shift_en) begin
      // First byte received lands least significant.
      word[ptr*8 +: 8] <= in_byte;
      ptr <= ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/scene_loader.sv
`timescale 1ns/1ns
`default_nettype none

module scene_loader
  import scene_pkg::*;
#(
  parameter int OBJ_BYTES = 6,
  parameter int MAX_OBJS  = 16
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               in_valid,
  input  logic [7:0]                         in_byte,
  output logic                               in_ready,
  output logic                               frame_done,
  input  logic [1:0]                         cam_sel,
  output logic [CAM_WIDTH-1:0]               cam_vec,
  input  logic [5:0]                         obj_raddr,
  output logic [OBJ_BYTES*8-1:0]             obj_rdata,
  output logic [$clog2(MAX_OBJS + 1)-1:0]    num_objs
);

  localparam int MAX_LEN = max_len(OBJ_BYTES);
  localparam int LEN_W   = $clog2(MAX_LEN + 1);

  logic                 step;
  logic                 cnt_start;
  logic [LEN_W-1:0]     cnt_len;
  logic                 cnt_last;
  logic                 shift_en;
  logic                 commit;
  opcode_t              op;
  logic [5:0]           sel;
  logic [MAX_LEN*8-1:0] word;

  // One byte moves per handshake.
  assign step = in_valid && in_ready;

  // **************************************************
  // Control
  // **************************************************

  load_fsm #(.OBJ_BYTES(OBJ_BYTES)) u_fsm (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_byte    (in_byte),
    .in_ready   (in_ready),
    .cnt_start  (cnt_start),
    .cnt_len    (cnt_len),
    .cnt_last   (cnt_last),
    .shift_en   (shift_en),
    .commit     (commit),
    .op         (op),
    .sel        (sel),
    .frame_done (frame_done)
  );

  byte_counter #(.OBJ_BYTES(OBJ_BYTES)) u_counter (
    .clk   (clk),
    .rst   (rst),
    .start (cnt_start),
    .len   (cnt_len),
    .step  (step),
    .last  (cnt_last)
  );

  // **************************************************
  // Data path
  // **************************************************

  payload_shifter #(.OBJ_BYTES(OBJ_BYTES)) u_shifter (
    .clk      (clk),
    .rst      (rst),
    .clear    (cnt_start),
    .shift_en (shift_en),
    .in_byte  (in_byte),
    .word     (word)
  );

  camera_regs #(.OBJ_BYTES(OBJ_BYTES)) u_cam (
    .clk     (clk),
    .rst     (rst),
    .commit  (commit),
    .op      (op),
    .sel     (sel),
    .word    (word),
    .cam_sel (cam_sel),
    .cam_vec (cam_vec)
  );

  object_store #(
    .OBJ_BYTES (OBJ_BYTES),
    .MAX_OBJS  (MAX_OBJS)
  ) u_objs (
    .clk       (clk),
    .rst       (rst),
    .commit    (commit),
    .op        (op),
    .sel       (sel),
    .word      (word),
    .obj_raddr (obj_raddr),
    .obj_rdata (obj_rdata),
    .num_objs  (num_objs)
  );

endmodule

`default_nettype wire

// File: source/scene_pkg.sv
package scene_pkg;

  // **************************************************
  // Loader FSM states and command opcodes
  // **************************************************

  typedef enum logic [1:0] {
    IDLE,
    PAYLOAD,
    COMMIT
  } load_state_t;

  typedef enum logic [1:0] {
    OP_CAM,
    OP_NUM_OBJS,
    OP_OBJ
  } opcode_t;

  // **************************************************
  // Camera vector geometry
  // **************************************************

  // Nine bytes per vector, three 24-bit components.
  localparam int CAM_BYTES = 9;
  localparam int CAM_WIDTH = CAM_BYTES * 8;

  // Longest payload of any frame.
  function automatic int max_len(input int obj_bytes);
    return (CAM_BYTES > obj_bytes) ? CAM_BYTES : obj_bytes;
  endfunction

endpackage

// File: tb.f
source/scene_pkg.sv
source/load_fsm.sv
source/byte_counter.sv
source/payload_shifter.sv
source/camera_regs.sv
source/object_store.sv
source/scene_loader.sv
sim/scene_loader_checker.sv
sim/scene_loader_tb.sv
